// ==== sram_axi_bridge_params.svh ====
`ifndef SRAM_AXI_BRIDGE_PARAMS_SVH
`define SRAM_AXI_BRIDGE_PARAMS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4
`define AXI_ID_W 4

// read ids name the requester, write id is fixed
`define INST_ID 0
`define DATA_ID 1
`define WR_ID 1

// single-beat incrementing bursts only
`define BURST_INCR 2'b01

// outstanding writes waiting on B
`define WR_MAX_PENDING 4
`define PEND_W 3

`endif

// ==== sram_axi_bridge_pkg.sv ====
`include "sram_axi_bridge_params.svh"

package sram_axi_bridge_pkg;

    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`DATA_W-1:0]   data_t;
    typedef logic [`STRB_W-1:0]   strb_t;
    // log2 of the byte count
    typedef logic [1:0]           sram_size_t;
    typedef logic [`AXI_ID_W-1:0] axi_id_t;
    typedef logic [`PEND_W-1:0]   pend_cnt_t;

    typedef struct packed {
        logic       req;
        logic       wr;
        sram_size_t size;
        strb_t      wstrb;
        addr_t      addr;
        data_t      wdata;
    } sram_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        data_t rdata;
    } sram_rsp_t;

    // axi size is 3 bits wide
    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [2:0] size;
    } axi_ar_t;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] size;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axi_w_t;

    typedef enum logic [1:0] {RD_IDLE, RD_AR, RD_R, RD_RET} rd_state_t;

    typedef enum logic {WR_IDLE, WR_SEND} wr_state_t;

endpackage

// ==== axi_read_fsm.sv ====
`include "sram_axi_bridge_params.svh"

module axi_read_fsm (
    input  logic                           clk,
    input  logic                           rst_n,
    input  sram_axi_bridge_pkg::sram_req_t inst_req,
    input  sram_axi_bridge_pkg::sram_req_t data_req,
    input  sram_axi_bridge_pkg::pend_cnt_t pend_cnt,
    input  logic                           arready,
    input  sram_axi_bridge_pkg::axi_id_t   rid,
    input  sram_axi_bridge_pkg::data_t     rdata,
    input  logic                           rvalid,
    output sram_axi_bridge_pkg::sram_rsp_t inst_rsp,
    output sram_axi_bridge_pkg::sram_rsp_t data_rd_rsp,
    output sram_axi_bridge_pkg::axi_ar_t   ar,
    output logic                           arvalid,
    output logic                           rready,
    output logic                           data_rd_busy
);

    sram_axi_bridge_pkg::rd_state_t state;
    sram_axi_bridge_pkg::rd_state_t state_nxt;
    sram_axi_bridge_pkg::axi_ar_t   ar_q;
    sram_axi_bridge_pkg::axi_id_t   ret_id;
    sram_axi_bridge_pkg::data_t     rdata_q;
    logic                           idle;
    logic                           data_pick;
    logic                           inst_pick;
    logic                           ret;

    assign idle = (state == sram_axi_bridge_pkg::RD_IDLE);
    assign ret  = (state == sram_axi_bridge_pkg::RD_RET);

    // data reads first, but never past a write still waiting on B
    assign data_pick = data_req.req && !data_req.wr && (pend_cnt == '0);
    assign inst_pick = inst_req.req && !data_pick;

    always_comb begin
        state_nxt = state;
        unique case (state)
            sram_axi_bridge_pkg::RD_IDLE: begin
                if (data_pick || inst_pick) begin
                    state_nxt = sram_axi_bridge_pkg::RD_AR;
                end
            end
            sram_axi_bridge_pkg::RD_AR: begin
                if (arready) begin
                    state_nxt = sram_axi_bridge_pkg::RD_R;
                end
            end
            sram_axi_bridge_pkg::RD_R: begin
                if (rvalid) begin
                    state_nxt = sram_axi_bridge_pkg::RD_RET;
                end
            end
            sram_axi_bridge_pkg::RD_RET: begin
                state_nxt = sram_axi_bridge_pkg::RD_IDLE;
            end
            default: begin
                state_nxt = sram_axi_bridge_pkg::RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sram_axi_bridge_pkg::RD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request latch, the id remembers the requester
    always_ff @(posedge clk) begin
        if (idle && data_pick) begin
            ar_q.id   <= sram_axi_bridge_pkg::axi_id_t'(`DATA_ID);
            ar_q.addr <= data_req.addr;
            ar_q.size <= {1'b0, data_req.size};
        end else if (idle && inst_pick) begin
            ar_q.id   <= sram_axi_bridge_pkg::axi_id_t'(`INST_ID);
            ar_q.addr <= inst_req.addr;
            ar_q.size <= {1'b0, inst_req.size};
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            ret_id  <= rid;
            rdata_q <= rdata;
        end
    end

    assign ar      = ar_q;
    assign arvalid = (state == sram_axi_bridge_pkg::RD_AR);
    assign rready  = (state == sram_axi_bridge_pkg::RD_R);

    assign data_rd_busy = !idle && (ar_q.id == sram_axi_bridge_pkg::axi_id_t'(`DATA_ID));

    assign inst_rsp.addr_ok = idle && inst_pick;
    assign inst_rsp.data_ok = ret && (ret_id == sram_axi_bridge_pkg::axi_id_t'(`INST_ID));
    assign inst_rsp.rdata   = rdata_q;

    assign data_rd_rsp.addr_ok = idle && data_pick;
    assign data_rd_rsp.data_ok = ret && (ret_id == sram_axi_bridge_pkg::axi_id_t'(`DATA_ID));
    assign data_rd_rsp.rdata   = rdata_q;

endmodule

// ==== axi_write_fsm.sv ====
`include "sram_axi_bridge_params.svh"

module axi_write_fsm (
    input  logic                           clk,
    input  logic                           rst_n,
    input  sram_axi_bridge_pkg::sram_req_t data_req,
    input  logic                           data_rd_busy,
    input  sram_axi_bridge_pkg::pend_cnt_t pend_cnt,
    input  logic                           awready,
    input  logic                           wready,
    input  logic                           bvalid,
    output sram_axi_bridge_pkg::sram_rsp_t data_wr_rsp,
    output sram_axi_bridge_pkg::axi_aw_t   aw,
    output sram_axi_bridge_pkg::axi_w_t    w,
    output logic                           awvalid,
    output logic                           wvalid,
    output logic                           aw_w_done,
    output logic                           b_done
);

    sram_axi_bridge_pkg::wr_state_t state;
    sram_axi_bridge_pkg::axi_aw_t   aw_q;
    sram_axi_bridge_pkg::axi_w_t    w_q;
    logic                           aw_sent;
    logic                           w_sent;
    logic                           can_take;
    logic                           take;
    logic                           sending;
    logic                           aw_fire;
    logic                           w_fire;
    logic                           b_ok_q;

    // only place the full count is checked
    assign can_take = (state == sram_axi_bridge_pkg::WR_IDLE) && !data_rd_busy
                      && (pend_cnt < `PEND_W'(`WR_MAX_PENDING));
    assign take     = can_take && data_req.req && data_req.wr;

    assign sending = (state == sram_axi_bridge_pkg::WR_SEND);
    assign awvalid = sending && !aw_sent;
    assign wvalid  = sending && !w_sent;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // AW and W may be accepted in either order
    assign aw_w_done = sending && (aw_sent || aw_fire) && (w_sent || w_fire);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= sram_axi_bridge_pkg::WR_IDLE;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else if (take) begin
            state   <= sram_axi_bridge_pkg::WR_SEND;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else if (aw_w_done) begin
            state <= sram_axi_bridge_pkg::WR_IDLE;
        end else begin
            aw_sent <= aw_sent || aw_fire;
            w_sent  <= w_sent || w_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            aw_q.addr <= data_req.addr;
            aw_q.size <= {1'b0, data_req.size};
            w_q.data  <= data_req.wdata;
            w_q.strb  <= data_req.wstrb;
        end
    end

    // bready is tied high, so every bvalid is a completion
    assign b_done = bvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_ok_q <= 1'b0;
        end else begin
            b_ok_q <= b_done;
        end
    end

    assign aw = aw_q;
    assign w  = w_q;

    assign data_wr_rsp.addr_ok = take;
    assign data_wr_rsp.data_ok = b_ok_q;
    assign data_wr_rsp.rdata   = '0;

endmodule

// ==== write_pending_counter.sv ====
`include "sram_axi_bridge_params.svh"

module write_pending_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           aw_w_done,
    input  logic                           b_done,
    output sram_axi_bridge_pkg::pend_cnt_t pend_cnt
);

    sram_axi_bridge_pkg::pend_cnt_t cnt;
    logic                           inc;
    logic                           dec;

    // a send and a response in the same cycle cancel out
    assign inc = aw_w_done && !b_done;
    assign dec = b_done && !aw_w_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (inc && (cnt != `PEND_W'(`WR_MAX_PENDING))) begin
            cnt <= cnt + sram_axi_bridge_pkg::pend_cnt_t'(1);
        end else if (dec && (cnt != '0)) begin
            cnt <= cnt - sram_axi_bridge_pkg::pend_cnt_t'(1);
        end
    end

    assign pend_cnt = cnt;

endmodule

// ==== sram_axi_bridge.sv ====
`include "sram_axi_bridge_params.svh"

module sram_axi_bridge (
    input  logic                           clk,
    input  logic                           rst_n,
    // sram side
    input  sram_axi_bridge_pkg::sram_req_t inst_req,
    input  sram_axi_bridge_pkg::sram_req_t data_req,
    output sram_axi_bridge_pkg::sram_rsp_t inst_rsp,
    output sram_axi_bridge_pkg::sram_rsp_t data_rsp,
    // read address
    output sram_axi_bridge_pkg::axi_id_t   arid,
    output sram_axi_bridge_pkg::addr_t     araddr,
    output logic [7:0]                     arlen,
    output logic [2:0]                     arsize,
    output logic [1:0]                     arburst,
    output logic [1:0]                     arlock,
    output logic [3:0]                     arcache,
    output logic [2:0]                     arprot,
    output logic                           arvalid,
    input  logic                           arready,
    // read data
    input  sram_axi_bridge_pkg::axi_id_t   rid,
    input  sram_axi_bridge_pkg::data_t     rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rlast,
    input  logic                           rvalid,
    output logic                           rready,
    // write address
    output sram_axi_bridge_pkg::axi_id_t   awid,
    output sram_axi_bridge_pkg::addr_t     awaddr,
    output logic [7:0]                     awlen,
    output logic [2:0]                     awsize,
    output logic [1:0]                     awburst,
    output logic [1:0]                     awlock,
    output logic [3:0]                     awcache,
    output logic [2:0]                     awprot,
    output logic                           awvalid,
    input  logic                           awready,
    // write data
    output sram_axi_bridge_pkg::axi_id_t   wid,
    output sram_axi_bridge_pkg::data_t     wdata,
    output sram_axi_bridge_pkg::strb_t     wstrb,
    output logic                           wlast,
    output logic                           wvalid,
    input  logic                           wready,
    // write response
    input  sram_axi_bridge_pkg::axi_id_t   bid,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready
);

    sram_axi_bridge_pkg::sram_rsp_t data_rd_rsp;
    sram_axi_bridge_pkg::sram_rsp_t data_wr_rsp;
    sram_axi_bridge_pkg::axi_ar_t   ar;
    sram_axi_bridge_pkg::axi_aw_t   aw;
    sram_axi_bridge_pkg::axi_w_t    w;
    sram_axi_bridge_pkg::pend_cnt_t pend_cnt;
    logic                           data_rd_busy;
    logic                           aw_w_done;
    logic                           b_done;

    axi_read_fsm axi_read_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_req     (inst_req),
        .data_req     (data_req),
        .pend_cnt     (pend_cnt),
        .arready      (arready),
        .rid          (rid),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .inst_rsp     (inst_rsp),
        .data_rd_rsp  (data_rd_rsp),
        .ar           (ar),
        .arvalid      (arvalid),
        .rready       (rready),
        .data_rd_busy (data_rd_busy)
    );

    axi_write_fsm axi_write_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_req     (data_req),
        .data_rd_busy (data_rd_busy),
        .pend_cnt     (pend_cnt),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .data_wr_rsp  (data_wr_rsp),
        .aw           (aw),
        .w            (w),
        .awvalid      (awvalid),
        .wvalid       (wvalid),
        .aw_w_done    (aw_w_done),
        .b_done       (b_done)
    );

    write_pending_counter write_pending_counter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_w_done (aw_w_done),
        .b_done    (b_done),
        .pend_cnt  (pend_cnt)
    );

    // data port has one kind of access in flight, so the two never overlap
    assign data_rsp = data_rd_rsp | data_wr_rsp;

    assign arid    = ar.id;
    assign araddr  = ar.addr;
    assign arsize  = ar.size;
    assign arlen   = 8'd0;
    assign arburst = `BURST_INCR;
    assign arlock  = 2'b00;
    assign arcache = 4'b0000;
    assign arprot  = 3'b000;

    assign awid    = sram_axi_bridge_pkg::axi_id_t'(`WR_ID);
    assign awaddr  = aw.addr;
    assign awsize  = aw.size;
    assign awlen   = 8'd0;
    assign awburst = `BURST_INCR;
    assign awlock  = 2'b00;
    assign awcache = 4'b0000;
    assign awprot  = 3'b000;

    // single beat, so every W is the last
    assign wid   = sram_axi_bridge_pkg::axi_id_t'(`WR_ID);
    assign wdata = w.data;
    assign wstrb = w.strb;
    assign wlast = 1'b1;

    // responses are taken as they come, rresp, rlast, bid and bresp unchecked
    assign bready = 1'b1;

endmodule

// ==== sram_axi_bridge_asserts.sv ====
module sram_axi_bridge_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input sram_axi_bridge_pkg::sram_req_t inst_req,
    input sram_axi_bridge_pkg::sram_req_t data_req,
    input sram_axi_bridge_pkg::sram_rsp_t inst_rsp,
    input sram_axi_bridge_pkg::sram_rsp_t data_rsp,
    input logic                           arvalid,
    input logic                           arready,
    input logic                           awvalid,
    input logic                           awready,
    input logic                           wvalid,
    input logic                           wready,
    input logic                           wlast,
    input logic [7:0]                     arlen,
    input logic [7:0]                     awlen
);
    timeunit 1ns;
    timeprecision 1ps;

    int inst_acc;
    int inst_done;
    int data_acc;
    int data_done;

    // accepted and answered requests per port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_acc <= 0;
            inst_done <= 0;
            data_acc <= 0;
            data_done <= 0;
        end else begin
            inst_acc <= inst_acc + int'(inst_req.req && inst_rsp.addr_ok);
            inst_done <= inst_done + int'(inst_rsp.data_ok);
            data_acc <= data_acc + int'(data_req.req && data_rsp.addr_ok);
            data_done <= data_done + int'(data_rsp.data_ok);
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
    single_beat: assert property (@(posedge clk) disable iff (!rst_n)
        arlen == 8'd0 && awlen == 8'd0) else $error("burst length is not zero");
    w_last: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> wlast) else $error("wvalid without wlast");
    inst_ok_once: assert property (@(posedge clk) disable iff (!rst_n)
        inst_rsp.data_ok |-> inst_done < inst_acc) else $error("extra instruction data_ok");
    data_ok_once: assert property (@(posedge clk) disable iff (!rst_n)
        data_rsp.data_ok |-> data_done < data_acc) else $error("extra data data_ok");

endmodule

// ==== sram_axi_bridge_tb.sv ====
`include "sram_axi_bridge_params.svh"

module sram_axi_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INST  = 40;
    localparam int N_DATA  = 60;
    localparam int N_REQ   = N_INST + N_DATA + 16;
    localparam int TIMEOUT = 200 * N_REQ;

    logic clk;
    logic rst_n;
    sram_axi_bridge_pkg::sram_req_t inst_req;
    sram_axi_bridge_pkg::sram_req_t data_req;
    sram_axi_bridge_pkg::sram_rsp_t inst_rsp;
    sram_axi_bridge_pkg::sram_rsp_t data_rsp;
    sram_axi_bridge_pkg::axi_id_t   arid;
    sram_axi_bridge_pkg::axi_id_t   rid;
    sram_axi_bridge_pkg::axi_id_t   awid;
    sram_axi_bridge_pkg::axi_id_t   wid;
    sram_axi_bridge_pkg::axi_id_t   bid;
    sram_axi_bridge_pkg::addr_t     araddr;
    sram_axi_bridge_pkg::addr_t     awaddr;
    sram_axi_bridge_pkg::data_t     rdata;
    sram_axi_bridge_pkg::data_t     wdata;
    sram_axi_bridge_pkg::strb_t     wstrb;
    logic [7:0] arlen;
    logic [7:0] awlen;
    logic [2:0] arsize;
    logic [2:0] awsize;
    logic [2:0] arprot;
    logic [2:0] awprot;
    logic [1:0] arburst;
    logic [1:0] awburst;
    logic [1:0] arlock;
    logic [1:0] awlock;
    logic [1:0] rresp;
    logic [1:0] bresp;
    logic [3:0] arcache;
    logic [3:0] awcache;
    logic arvalid;
    logic arready;
    logic rlast;
    logic rvalid;
    logic rready;
    logic awvalid;
    logic awready;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;

    // data window is words 0..63 and instruction window words 64..127
    sram_axi_bridge_pkg::data_t mem [0:127];
    sram_axi_bridge_pkg::data_t shadow [0:127];
    sram_axi_bridge_pkg::data_t inst_exp_q[$];
    sram_axi_bridge_pkg::data_t data_exp_q[$];
    bit                         data_is_rd_q[$];
    sram_axi_bridge_pkg::addr_t aw_addr_q[$];
    sram_axi_bridge_pkg::data_t w_data_q[$];
    sram_axi_bridge_pkg::strb_t w_strb_q[$];

    int inst_outstanding = 0;
    int data_outstanding = 0;
    int wr_outstanding = 0;
    int wr_peak = 0;
    int writes_issued = 0;
    int writes_seen = 0;
    int error_count = 0;
    int cycle_cnt = 0;
    bit b_hold = 1'b0;
    bit r_pend = 1'b0;
    bit r_done = 1'b0;
    bit b_seen = 1'b0;
    int unsigned r_delay = 0;
    int unsigned b_delay = 0;
    int b_pend = 0;
    sram_axi_bridge_pkg::axi_id_t r_id_q;
    sram_axi_bridge_pkg::data_t   r_data_q;

    sram_axi_bridge sram_axi_bridge_inst (.*);

    bind sram_axi_bridge sram_axi_bridge_asserts asserts_inst (.*);

    always #4 clk = ~clk;

    function automatic sram_axi_bridge_pkg::data_t fill_word(int unsigned idx);
        logic [31:0] a;
        a = 32'(idx << 2);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h13572468;
    endfunction

    // byte lanes with a set strobe take the new data
    function automatic sram_axi_bridge_pkg::data_t merge_write(
        sram_axi_bridge_pkg::data_t old, sram_axi_bridge_pkg::data_t nw,
        sram_axi_bridge_pkg::strb_t strb);
        sram_axi_bridge_pkg::data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_run(string what);
        error_count++;
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
        stop_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else value_error(name, got, exp);
    endtask

    task automatic inst_read(int unsigned idx);
        @(negedge clk);
        inst_req = '0;
        inst_req.req = 1'b1;
        inst_req.size = 2'd2;
        inst_req.addr = 32'(idx << 2);
        do @(posedge clk); while (!inst_rsp.addr_ok);
        inst_exp_q.push_back(shadow[idx]);
        inst_outstanding++;
        @(negedge clk);
        inst_req.req = 1'b0;
    endtask

    task automatic data_write(int unsigned idx, sram_axi_bridge_pkg::data_t d,
                              sram_axi_bridge_pkg::strb_t strb);
        @(negedge clk);
        data_req = '0;
        data_req.req = 1'b1;
        data_req.wr = 1'b1;
        data_req.size = 2'd2;
        data_req.wstrb = strb;
        data_req.addr = 32'(idx << 2);
        data_req.wdata = d;
        do @(posedge clk); while (!data_rsp.addr_ok);
        shadow[idx] = merge_write(shadow[idx], d, strb);
        data_is_rd_q.push_back(1'b0);
        data_exp_q.push_back('0);
        data_outstanding++;
        writes_issued++;
        wr_outstanding++;
        if (wr_outstanding > wr_peak) begin
            wr_peak = wr_outstanding;
        end
        assert (wr_outstanding <= `WR_MAX_PENDING)
            else stop_run("more writes accepted than the pending limit allows");
        @(negedge clk);
        data_req.req = 1'b0;
    endtask

    // the read goes out only once every write reached the slave
    task automatic data_read(int unsigned idx);
        wait (writes_seen == writes_issued);
        @(negedge clk);
        data_req = '0;
        data_req.req = 1'b1;
        data_req.size = 2'd2;
        data_req.addr = 32'(idx << 2);
        do @(posedge clk); while (!data_rsp.addr_ok);
        assert (wr_outstanding == 0)
            else stop_run("data read accepted while a write still waits for its B response");
        data_is_rd_q.push_back(1'b1);
        data_exp_q.push_back(shadow[idx]);
        data_outstanding++;
        @(negedge clk);
        data_req.req = 1'b0;
        wait (data_outstanding == 0);
    endtask

    task automatic check_read_priority();
        wait (inst_outstanding == 0 && data_outstanding == 0 && wr_outstanding == 0);
        @(negedge clk);
        data_req = '0;
        data_req.req = 1'b1;
        data_req.size = 2'd2;
        data_req.addr = 32'd40;
        inst_req = '0;
        inst_req.req = 1'b1;
        inst_req.size = 2'd2;
        inst_req.addr = 32'd400;
        @(posedge clk);
        assert (data_rsp.addr_ok && !inst_rsp.addr_ok)
            else stop_run("data read did not win over a same-cycle instruction read");
        data_is_rd_q.push_back(1'b1);
        data_exp_q.push_back(shadow[10]);
        data_outstanding++;
        @(negedge clk);
        data_req.req = 1'b0;
        do @(posedge clk); while (!inst_rsp.addr_ok);
        inst_exp_q.push_back(shadow[100]);
        inst_outstanding++;
        @(negedge clk);
        inst_req.req = 1'b0;
    endtask

    task automatic inst_stream(int n);
        for (int i = 0; i < n; i++) begin
            inst_read(64 + ($urandom % 64));
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    task automatic data_stream(int n);
        for (int i = 0; i < n; i++) begin
            if (($urandom % 5) < 2) begin
                data_write($urandom % 64, $urandom,
                           sram_axi_bridge_pkg::strb_t'(($urandom % 15) + 1));
            end else begin
                data_read($urandom % 64);
            end
        end
    endtask

    // slave model samples handshakes at the rising edge
    always @(posedge clk) begin
        if (arvalid && arready) begin
            compare_field("arsize", 32'(arsize), 32'd2);
            compare_field("{arburst,arlock,arcache,arprot}",
                          32'({arburst, arlock, arcache, arprot}),
                          32'({2'b01, 2'b00, 4'h0, 3'h0}));
            r_pend = 1'b1;
            r_id_q = arid;
            r_data_q = mem[araddr[8:2]];
            r_delay = $urandom % 4;
        end
        if (rvalid && rready) begin
            r_done = 1'b1;
        end
        if (awvalid && awready) begin
            compare_field("awid", 32'(awid), 32'(`WR_ID));
            compare_field("awsize", 32'(awsize), 32'd2);
            compare_field("{awburst,awlock,awcache,awprot}",
                          32'({awburst, awlock, awcache, awprot}),
                          32'({2'b01, 2'b00, 4'h0, 3'h0}));
            aw_addr_q.push_back(awaddr);
        end
        if (wvalid && wready) begin
            compare_field("wid", 32'(wid), 32'(`WR_ID));
            w_data_q.push_back(wdata);
            w_strb_q.push_back(wstrb);
        end
        while (aw_addr_q.size() > 0 && w_data_q.size() > 0) begin
            mem[aw_addr_q[0][8:2]] = merge_write(mem[aw_addr_q[0][8:2]], w_data_q[0], w_strb_q[0]);
            void'(aw_addr_q.pop_front());
            void'(w_data_q.pop_front());
            void'(w_strb_q.pop_front());
            b_pend++;
            writes_seen++;
        end
        if (bvalid && bready) begin
            b_seen = 1'b1;
            wr_outstanding--;
        end
    end

    // slave model drives new values at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            arready = ($urandom % 3) != 0;
            awready = ($urandom % 3) != 0;
            wready = ($urandom % 3) != 0;
            if (r_done) begin
                rvalid = 1'b0;
                r_done = 1'b0;
            end else if (r_pend && !rvalid) begin
                if (r_delay == 0) begin
                    rvalid = 1'b1;
                    rid = r_id_q;
                    rdata = r_data_q;
                    r_pend = 1'b0;
                end else begin
                    r_delay--;
                end
            end
            if (b_seen) begin
                bvalid = 1'b0;
                b_seen = 1'b0;
            end else if (!bvalid && b_pend > 0 && !b_hold) begin
                if (b_delay == 0) begin
                    bvalid = 1'b1;
                    b_pend--;
                    b_delay = $urandom % 4;
                end else begin
                    b_delay--;
                end
            end
        end
    end

    always @(posedge clk) begin
        sram_axi_bridge_pkg::data_t exp;
        bit is_rd;
        if (inst_rsp.data_ok) begin
            assert (inst_exp_q.size() > 0)
                else stop_run("instruction data_ok without an outstanding read");
            exp = inst_exp_q.pop_front();
            inst_outstanding--;
            assert (inst_rsp.rdata == exp) else value_error("inst_rsp.rdata", inst_rsp.rdata, exp);
        end
        if (data_rsp.data_ok) begin
            assert (data_exp_q.size() > 0)
                else stop_run("data data_ok without an outstanding request");
            exp = data_exp_q.pop_front();
            is_rd = data_is_rd_q.pop_front();
            data_outstanding--;
            if (is_rd) begin
                assert (data_rsp.rdata == exp)
                    else value_error("data_rsp.rdata", data_rsp.rdata, exp);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            stop_run("timeout, requests still waiting for data_ok");
        end
    end

    initial begin
        void'($urandom(32'h37189113));
        clk = 1'b0;
        rst_n = 1'b0;
        inst_req = '0;
        data_req = '0;
        {arready, awready, wready, rvalid, bvalid, rlast} = '0;
        {rid, bid, rresp, bresp} = '0;
        rdata = '0;
        for (int i = 0; i < 128; i++) begin
            mem[i] = fill_word(i);
            shadow[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (4) begin
            @(posedge clk);
            assert (!arvalid && !awvalid && !wvalid && !inst_rsp.data_ok && !data_rsp.data_ok
                    && !inst_rsp.addr_ok && !data_rsp.addr_ok)
                else stop_run("bridge active before the first request");
        end

        // read behind a write whose B is late
        b_hold = 1'b1;
        data_write(5, 32'hcafef00d, 4'b0101);
        fork
            begin
                repeat (25) @(posedge clk);
                b_hold = 1'b0;
            end
        join_none
        data_read(5);

        check_read_priority();

        // fill the pending count with B held back
        wait (data_outstanding == 0 && inst_outstanding == 0);
        b_hold = 1'b1;
        fork
            begin
                repeat (60) @(posedge clk);
                b_hold = 1'b0;
            end
        join_none
        for (int i = 0; i < 7; i++) begin
            data_write(20 + i, $urandom, 4'hf);
        end
        assert (wr_peak == `WR_MAX_PENDING) else stop_run("pending write limit never reached");

        fork
            inst_stream(N_INST);
            data_stream(N_DATA);
        join

        wait (inst_outstanding == 0 && data_outstanding == 0 && wr_outstanding == 0);
        repeat (5) @(posedge clk);
        if (error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run("checks failed during the run");
        end
    end

endmodule

// ==== sram_axi_bridge.f ====
+incdir+.
sram_axi_bridge_pkg.sv
axi_read_fsm.sv
axi_write_fsm.sv
write_pending_counter.sv
sram_axi_bridge.sv
sram_axi_bridge_asserts.sv
sram_axi_bridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Mdir obj_dir
TOP       := sram_axi_bridge_tb
FILELIST  := sram_axi_bridge.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "test failed"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "test ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
